// File: hw/tx_filt_config.svh
`ifndef TX_FILT_CONFIG_SVH
`define TX_FILT_CONFIG_SVH

// Filter length, odd so there is one centre tap
`define TX_TAPS 81

// Folded taps, mirrored pairs plus the centre
`define TX_HALF_TAPS 41

// Samples are 1s17
`define TX_SAMPLE_W 18

// Fraction bits of samples and coefficients
`define TX_FRAC_W 17

// Coefficient word, same format as a sample
`define TX_COEFF_W 18

// Partial sums and products after the shift
`define TX_ACC_W 26

`endif

// File: hw/tx_sample_pkg.sv
`default_nettype none

`include "tx_filt_config.svh"

package tx_sample_pkg;

	// Input and output sample, 1s17
	typedef logic signed [`TX_SAMPLE_W-1:0] sample_t;

	// Sum of two mirrored samples, 2s17
	typedef logic signed [`TX_SAMPLE_W:0] folded_t;

	// One tap product after the shift back to 17 fraction bits
	typedef logic signed [`TX_ACC_W-1:0] product_t;

	// Sum of several products
	// Wide enough for a full bank at the largest PAM levels
	typedef logic signed [`TX_ACC_W-1:0] acc_t;

	// All folded taps of the filter, index 0 is the outermost pair
	typedef folded_t folded_vec_t [`TX_HALF_TAPS];

endpackage

`default_nettype wire

// File: hw/tx_coeff_pkg.sv
`default_nettype none

`include "tx_filt_config.svh"

package tx_coeff_pkg;

	// Signed coefficient, 1.0 is 131072
	typedef logic signed [`TX_COEFF_W-1:0] coeff_t;

	// Pulse shape, first half plus the centre tap
	// Tap k and tap 80-k share entry k
	localparam coeff_t COEFF [`TX_HALF_TAPS] = '{
		18'sd280,
		18'sd328,
		18'sd104,
		-18'sd252,
		-18'sd464,
		-18'sd332,
		18'sd104,
		18'sd560,
		18'sd672,
		18'sd276,
		// Tap 10
		-18'sd432,
		-18'sd972,
		-18'sd892,
		-18'sd124,
		18'sd912,
		18'sd1500,
		18'sd1116,
		-18'sd164,
		-18'sd1596,
		-18'sd2184,
		// Tap 20, last one of bank A
		-18'sd1336,
		18'sd644,
		18'sd2580,
		18'sd3092,
		18'sd1532,
		-18'sd1444,
		-18'sd4056,
		-18'sd4388,
		-18'sd1700,
		18'sd2848,
		// Tap 30
		18'sd6532,
		18'sd6544,
		18'sd1824,
		-18'sd5780,
		-18'sd11908,
		-18'sd11592,
		-18'sd1904,
		18'sd16116,
		18'sd37316,
		18'sd54352,
		// Centre tap
		18'sd60864
	};

endpackage

`default_nettype wire

// File: hw/sample_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_filt_config.svh"

module sample_delay_line (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        sam_clk_en,
	input  tx_sample_pkg::sample_t     x_in,
	output tx_sample_pkg::folded_vec_t folded
);

	import tx_sample_pkg::*;

	localparam int LAST   = `TX_TAPS - 1;
	localparam int CENTRE = `TX_HALF_TAPS - 1;

	// Stage 0 is the newest sample
	sample_t stage [`TX_TAPS];

	// Newest sample enters, older samples move one place per enable
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `TX_TAPS; i++)
			begin
				stage[i] <= '0;
			end
		end
		else if (sam_clk_en)
		begin
			stage[0] <= x_in;
			for (int i = 1; i < `TX_TAPS; i++)
			begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// Mirrored pairs share a coefficient, so add them first
	always_comb
	begin
		for (int k = 0; k < CENTRE; k++)
		begin
			folded[k] = folded_t'(stage[k]) + folded_t'(stage[LAST-k]);
		end
		// Centre tap has no partner
		folded[CENTRE] = folded_t'(stage[CENTRE]);
	end

endmodule

`default_nettype wire

// File: hw/tap_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_filt_config.svh"

module tap_bank #(
	parameter int FIRST_TAP = 0,
	parameter int NUM_TAPS  = 21
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    sam_clk_en,
	input  tx_sample_pkg::folded_t folded [NUM_TAPS],
	output tx_sample_pkg::acc_t    partial
);

	import tx_sample_pkg::*;
	import tx_coeff_pkg::*;

	// Full product of a folded sum and a coefficient
	localparam int MULT_W = $bits(folded_t) + $bits(coeff_t);

	typedef logic signed [MULT_W-1:0] mult_t;

	mult_t    mult_full [NUM_TAPS];
	product_t product   [NUM_TAPS];
	acc_t     bank_sum;

	// One multiplier per tap
	always_comb
	begin
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			mult_full[i] = mult_t'(folded[i]) * mult_t'(COEFF[FIRST_TAP + i]);
			// Back to 17 fraction bits, truncating toward minus infinity
			product[i]   = product_t'(mult_full[i] >>> `TX_FRAC_W);
		end
	end

	// Adder chain over the bank
	always_comb
	begin
		bank_sum = '0;
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			bank_sum = bank_sum + acc_t'(product[i]);
		end
	end

	// Pipeline stage between the banks and the combiner
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			partial <= '0;
		end
		else if (sam_clk_en)
		begin
			partial <= bank_sum;
		end
	end

endmodule

`default_nettype wire

// File: hw/output_combiner.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_filt_config.svh"

module output_combiner (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    sam_clk_en,
	input  tx_sample_pkg::acc_t    partial_a,
	input  tx_sample_pkg::acc_t    partial_b,
	output tx_sample_pkg::sample_t y
);

	import tx_sample_pkg::*;

	// One bit of growth for the final add
	logic signed [`TX_ACC_W:0] total;

	always_comb
	begin
		total = $signed({partial_a[`TX_ACC_W-1], partial_a})
			+ $signed({partial_b[`TX_ACC_W-1], partial_b});
	end

	// Output keeps the low 18 bits, wraps on overflow
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			y <= '0;
		end
		else if (sam_clk_en)
		begin
			y <= sample_t'(total[`TX_SAMPLE_W-1:0]);
		end
	end

endmodule

`default_nettype wire

// File: hw/tx_pulse_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_filt_config.svh"

module tx_pulse_filter (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    sam_clk_en,
	input  tx_sample_pkg::sample_t x_in,
	output tx_sample_pkg::sample_t y
);

	import tx_sample_pkg::*;

	// Bank split, A holds the outer taps
	localparam int A_FIRST = 0;
	localparam int A_NUM   = 21;
	localparam int B_FIRST = A_FIRST + A_NUM;
	localparam int B_NUM   = `TX_HALF_TAPS - B_FIRST;

	folded_vec_t folded;
	acc_t        partial_a;
	acc_t        partial_b;

	sample_delay_line i_delay_line (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.x_in       (x_in),
		.folded     (folded)
	);

	tap_bank #(
		.FIRST_TAP (A_FIRST),
		.NUM_TAPS  (A_NUM)
	) i_bank_a (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.folded     (folded[A_FIRST:A_FIRST+A_NUM-1]),
		.partial    (partial_a)
	);

	// Inner taps up to the centre
	tap_bank #(
		.FIRST_TAP (B_FIRST),
		.NUM_TAPS  (B_NUM)
	) i_bank_b (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.folded     (folded[B_FIRST:B_FIRST+B_NUM-1]),
		.partial    (partial_b)
	);

	output_combiner i_combiner (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.partial_a  (partial_a),
		.partial_b  (partial_b),
		.y          (y)
	);

endmodule

`default_nettype wire

// File: bench/filter_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_filt_config.svh"

module filter_checker (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    sam_clk_en,
	input  tx_sample_pkg::sample_t x_in,
	input  tx_sample_pkg::sample_t y,
	input  wire                    exp_valid,
	input  tx_sample_pkg::sample_t exp_y,
	output int                     error_count,
	output int                     check_count
);

	import tx_sample_pkg::*;
	import tx_coeff_pkg::*;

	// Sample history, index 0 is the newest
	longint  hist [`TX_TAPS];
	// Filter sum one enable before it reaches the output
	longint  mid_sum;
	sample_t model_y;
	logic    table_valid;
	sample_t table_y;
	bit      armed;
	int      errors = 0;
	int      checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// Symmetric pulse shape applied to the history
	function automatic longint filter_sum();
		longint acc;
		longint pair;
		acc = 0;
		for (int k = 0; k < `TX_HALF_TAPS; k++)
		begin
			if (k == `TX_HALF_TAPS - 1)
			begin
				pair = hist[k];
			end
			else
			begin
				pair = hist[k] + hist[`TX_TAPS-1-k];
			end
			// Each product floored to 17 fraction bits before the add
			acc += (pair * longint'(COEFF[k])) >>> `TX_FRAC_W;
		end
		return acc;
	endfunction

	// Two enables from capture to output, 18-bit wrap at the end
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `TX_TAPS; i++)
			begin
				hist[i] <= 0;
			end
			mid_sum <= 0;
			model_y <= '0;
		end
		else if (sam_clk_en)
		begin
			model_y <= sample_t'(mid_sum);
			mid_sum <= filter_sum();
			hist[0] <= longint'(x_in);
			for (int i = 1; i < `TX_TAPS; i++)
			begin
				hist[i] <= hist[i-1];
			end
		end
	end

	// Table value of a row applies after the edge that takes the row
	always @(posedge clk)
	begin
		armed       <= 1'b1;
		table_valid <= exp_valid;
		table_y     <= exp_y;
	end

	always @(negedge clk)
	begin
		if (armed)
		begin
			checks++;
			if (y !== model_y)
			begin
				errors++;
				$display("error at %0d ns: y is %0d, model expects %0d", $time, y, model_y);
			end
			if (table_valid && y !== table_y)
			begin
				errors++;
				$display("error at %0d ns: y is %0d, table expects %0d", $time, y, table_y);
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_tx_pulse_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_filt_config.svh"

module tb_tx_pulse_filter;

	import tx_sample_pkg::*;
	import tx_coeff_pkg::*;

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 8;
	localparam int SLACK_CYCLES = 200;

	logic    clk;
	logic    reset;
	logic    sam_clk_en;
	sample_t x_in;
	sample_t y;
	logic    exp_valid;
	sample_t exp_y;
	int      error_count;
	int      check_count;
	int      cycle_count   = 0;
	int      timeout_limit = 0;

	// Stimulus table, one row per clock
	bit      row_en  [$];
	sample_t row_x   [$];
	bit      row_rst [$];
	bit      row_chk [$];
	sample_t row_exp [$];

	tx_pulse_filter i_dut (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.x_in       (x_in),
		.y          (y)
	);

	filter_checker i_checker (
		.clk         (clk),
		.reset       (reset),
		.sam_clk_en  (sam_clk_en),
		.x_in        (x_in),
		.y           (y),
		.exp_valid   (exp_valid),
		.exp_y       (exp_y),
		.error_count (error_count),
		.check_count (check_count)
	);

	function automatic sample_t pam_level();
		case ($urandom % 4)
			0: return -18'sd98304;
			1: return -18'sd32768;
			2: return 18'sd32768;
			default: return 18'sd98304;
		endcase
	endfunction

	// Output j enables after the response starts, for a lone sample amp
	function automatic sample_t impulse_tap(input sample_t amp, input int j);
		int     k;
		longint p;
		if (j < 0 || j > `TX_TAPS - 1)
		begin
			return '0;
		end
		k = (j < `TX_HALF_TAPS) ? j : `TX_TAPS - 1 - j;
		p = longint'(amp) * longint'(COEFF[k]);
		return sample_t'(p >>> `TX_FRAC_W);
	endfunction

	task automatic add_row(input bit en, input sample_t x, input bit rst, input bit chk,
		input sample_t exp_val);
		row_en.push_back(en);
		row_x.push_back(x);
		row_rst.push_back(rst);
		row_chk.push_back(chk);
		row_exp.push_back(exp_val);
	endtask

	// Lone sample then zeros, with a run of idle cycles before enable gap_at
	task automatic add_impulse(input sample_t amp, input int n_enables, input int gap_at,
		input int gap_len);
		sample_t y_exp;
		y_exp = '0;
		add_row(1'b1, amp, 1'b0, 1'b1, y_exp);
		for (int age = 1; age <= n_enables; age++)
		begin
			if (age == gap_at)
			begin
				for (int g = 0; g < gap_len; g++)
				begin
					add_row(1'b0, pam_level(), 1'b0, 1'b1, y_exp);
				end
			end
			y_exp = impulse_tap(amp, age - 2);
			add_row(1'b1, '0, 1'b0, 1'b1, y_exp);
		end
	endtask

	task automatic build_table();
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			add_row(1'b0, '0, 1'b1, 1'b1, '0);
		end
		// Zero samples give a zero output
		for (int i = 0; i < 20; i++)
		begin
			add_row(i % 3 != 2, '0, 1'b0, 1'b1, '0);
		end
		add_impulse(18'sd98304, 90, 30, 6);
		// PAM stream, mostly back to back, then widely spaced
		for (int i = 0; i < 220; i++)
		begin
			add_row(($urandom % 4) != 0, pam_level(), 1'b0, 1'b0, '0);
		end
		for (int i = 0; i < 60; i++)
		begin
			add_row(i % 5 == 0, pam_level(), 1'b0, 1'b0, '0);
		end
		// Reset in mid stream, samples offered meanwhile are lost
		for (int i = 0; i < 3; i++)
		begin
			add_row(1'b1, pam_level(), 1'b1, 1'b1, '0);
		end
		add_impulse(-18'sd32768, 86, 50, 4);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (timeout_limit != 0 && cycle_count > timeout_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", timeout_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(29));
		reset      = 1'b1;
		sam_clk_en = 1'b0;
		x_in       = '0;
		exp_valid  = 1'b0;
		exp_y      = '0;
		build_table();
		timeout_limit = row_en.size() + SLACK_CYCLES;
		for (int i = 0; i < row_en.size(); i++)
		begin
			@(posedge clk);
			reset      <= row_rst[i];
			sam_clk_en <= row_en[i];
			x_in       <= row_x[i];
			exp_valid  <= row_chk[i];
			exp_y      <= row_exp[i];
		end
		@(posedge clk);
		sam_clk_en <= 1'b0;
		exp_valid  <= 1'b0;
		repeat (2) @(posedge clk);
		$display("Closing: %0d errors in %0d checks", error_count, check_count);
		if (error_count == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/tx_sample_pkg.sv
hw/tx_coeff_pkg.sv
hw/sample_delay_line.sv
hw/tap_bank.sv
hw/output_combiner.sv
hw/tx_pulse_filter.sv
bench/filter_checker.sv
bench/tb_tx_pulse_filter.sv

// File: Bender.yml
package:
  name: tx_pulse_filter

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/tx_sample_pkg.sv
      - hw/tx_coeff_pkg.sv
      - hw/sample_delay_line.sv
      - hw/tap_bank.sv
      - hw/output_combiner.sv
      - hw/tx_pulse_filter.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/filter_checker.sv
      - bench/tb_tx_pulse_filter.sv
